/* hw/multdiv_config.svh */
`ifndef MULTDIV_CONFIG_SVH
`define MULTDIV_CONFIG_SVH

// Operand and result width
`define MD_WIDTH 32

// One iteration per operand bit
`define MD_ITERATIONS 32

// Wide enough to hold MD_ITERATIONS itself
`define MD_COUNT_WIDTH 6

`endif

/* hw/multdiv_pkg.sv */
`include "multdiv_config.svh"

package multdiv_pkg;

	// Operation held for the length of a run
	typedef enum logic {
		MD_MULT = 1'b0,
		MD_DIV  = 1'b1
	} md_op_e;

	// Request from the active sequencer to the shared datapath
	typedef struct packed {
		logic                     reg_load;
		logic [2*`MD_WIDTH-1:0]   reg_next;
		logic [`MD_WIDTH-1:0]     add_a;
		logic [`MD_WIDTH-1:0]     add_b;
		logic                     subtract;
	} md_step_t;

	// Datapath view returned to both sequencers
	typedef struct packed {
		logic [2*`MD_WIDTH-1:0]   reg_value;
		logic [`MD_WIDTH-1:0]     sum;
		logic                     sum_negative;
		logic                     sum_overflow;
	} md_state_t;

endpackage

/* hw/md_datapath.sv */
`timescale 1ns/1ps
`include "multdiv_config.svh"

module md_datapath (
	input  logic                   clock,
	input  logic                   arst_n,
	input  multdiv_pkg::md_step_t  step,
	output multdiv_pkg::md_state_t state
);

	logic [2*`MD_WIDTH-1:0] work_q;
	logic [`MD_WIDTH-1:0]   operand_b;
	logic [`MD_WIDTH-1:0]   sum;
	logic                   overflow;

	// Subtraction as a + ~b + 1
	assign operand_b = step.subtract ? ~step.add_b : step.add_b;
	assign sum = step.add_a + operand_b + `MD_WIDTH'(step.subtract);

	// Same-sign inputs giving a result of the other sign
	assign overflow = (step.add_a[`MD_WIDTH-1] == operand_b[`MD_WIDTH-1]) &&
		(sum[`MD_WIDTH-1] != step.add_a[`MD_WIDTH-1]);

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			work_q <= '0;
		end
		else if (step.reg_load)
		begin
			work_q <= step.reg_next;
		end
	end

	assign state.reg_value = work_q;
	assign state.sum = sum;
	assign state.sum_negative = sum[`MD_WIDTH-1];
	assign state.sum_overflow = overflow;

endmodule

/* hw/mult_seq.sv */
`timescale 1ns/1ps
`include "multdiv_config.svh"

module mult_seq (
	input  logic                   clock,
	input  logic                   arst_n,
	input  logic                   start,
	input  logic [`MD_WIDTH-1:0]   multiplicand,
	input  logic [`MD_WIDTH-1:0]   multiplier,
	input  multdiv_pkg::md_state_t state,
	output multdiv_pkg::md_step_t  step,
	output logic [`MD_WIDTH-1:0]   product_low,
	output logic                   overflow
);

	logic [`MD_WIDTH-1:0] mcand_q;
	logic                 booth_q;
	logic [`MD_WIDTH-1:0] high_half;
	logic [`MD_WIDTH-1:0] low_half;
	logic [1:0]           pair;
	logic                 sum_sign;

	assign high_half = state.reg_value[2*`MD_WIDTH-1:`MD_WIDTH];
	assign low_half = state.reg_value[`MD_WIDTH-1:0];

	// Booth pair is the current multiplier bit and the one shifted out before it
	assign pair = {low_half[0], booth_q};

	// True sign of the partial sum, bit 31 is wrong when the add overflowed
	assign sum_sign = state.sum_negative ^ state.sum_overflow;

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			mcand_q <= '0;
			booth_q <= 1'b0;
		end
		else if (start)
		begin
			mcand_q <= multiplicand;
			booth_q <= 1'b0;
		end
		else
		begin
			booth_q <= low_half[0];
		end
	end

	always_comb
	begin
		step.reg_load = 1'b1;
		step.add_a = high_half;
		step.subtract = (pair == 2'b10);
		// 00 and 11 only shift
		if (pair == 2'b01 || pair == 2'b10)
			step.add_b = mcand_q;
		else
			step.add_b = '0;
		// Arithmetic right shift of {sum, low half}
		step.reg_next = {sum_sign, state.sum, low_half[`MD_WIDTH-1:1]};
		if (start)
			step.reg_next = {{`MD_WIDTH{1'b0}}, multiplier};
	end

	assign product_low = low_half;

	// High word must be pure sign extension of the low word
	assign overflow = (high_half != {`MD_WIDTH{low_half[`MD_WIDTH-1]}});

endmodule

/* hw/div_seq.sv */
`timescale 1ns/1ps
`include "multdiv_config.svh"

module div_seq (
	input  logic                   clock,
	input  logic                   arst_n,
	input  logic                   start,
	input  logic [`MD_WIDTH-1:0]   dividend,
	input  logic [`MD_WIDTH-1:0]   divisor,
	input  multdiv_pkg::md_state_t state,
	output multdiv_pkg::md_step_t  step,
	output logic [`MD_WIDTH-1:0]   quotient,
	output logic                   divide_by_zero
);

	logic [`MD_WIDTH-1:0] divisor_mag_q;
	logic                 negate_q;
	logic                 zero_q;
	logic [`MD_WIDTH-1:0] dividend_mag;
	logic [`MD_WIDTH-1:0] rem_shifted;
	logic [`MD_WIDTH-1:0] quo;
	logic                 below;

	assign dividend_mag = dividend[`MD_WIDTH-1] ? -dividend : dividend;

	// Remainder shifted left by one, taking the next dividend bit
	assign rem_shifted = state.reg_value[2*`MD_WIDTH-2:`MD_WIDTH-1];
	assign quo = state.reg_value[`MD_WIDTH-1:0];

	// Unsigned compare from the signed flags
	// rem_shifted < divisor when the signed order flips on differing top bits
	assign below = state.sum_negative ^ state.sum_overflow ^
		rem_shifted[`MD_WIDTH-1] ^ divisor_mag_q[`MD_WIDTH-1];

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			divisor_mag_q <= '0;
			negate_q <= 1'b0;
			zero_q <= 1'b0;
		end
		else if (start)
		begin
			divisor_mag_q <= divisor[`MD_WIDTH-1] ? -divisor : divisor;
			negate_q <= dividend[`MD_WIDTH-1] ^ divisor[`MD_WIDTH-1];
			zero_q <= (divisor == '0);
		end
	end

	always_comb
	begin
		step.reg_load = 1'b1;
		step.add_a = rem_shifted;
		step.add_b = divisor_mag_q;
		step.subtract = 1'b1;
		if (start)
			step.reg_next = {{`MD_WIDTH{1'b0}}, dividend_mag};
		else if (below)
			step.reg_next = {rem_shifted, quo[`MD_WIDTH-2:0], 1'b0};
		else
			step.reg_next = {state.sum, quo[`MD_WIDTH-2:0], 1'b1};
	end

	// Sign fix-up on the final magnitude
	always_comb
	begin
		if (zero_q)
			quotient = '0;
		else if (negate_q)
			quotient = -quo;
		else
			quotient = quo;
	end

	assign divide_by_zero = zero_q;

endmodule

/* hw/md_control.sv */
`timescale 1ns/1ps
`include "multdiv_config.svh"

module md_control (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 start_mult,
	input  logic                 start_div,
	input  logic [`MD_WIDTH-1:0] mult_result,
	input  logic [`MD_WIDTH-1:0] div_result,
	input  logic                 mult_exception,
	input  logic                 div_exception,
	output logic                 mult_start,
	output logic                 div_start,
	output multdiv_pkg::md_op_e  op,
	output logic [`MD_WIDTH-1:0] result,
	output logic                 exception,
	output logic                 result_ready,
	output logic                 in_progress
);
	import multdiv_pkg::*;

	md_op_e                    op_q;
	logic                      start;
	logic                      done;
	logic [`MD_COUNT_WIDTH-1:0] count_q;

	assign start = start_mult | start_div;

	// Multiply wins on simultaneous strobes, new op is visible in the strobe cycle
	always_comb
	begin
		if (start_mult)
			op = MD_MULT;
		else if (start_div)
			op = MD_DIV;
		else
			op = op_q;
	end

	assign mult_start = start & (op == MD_MULT);
	assign div_start = start & (op == MD_DIV);

	assign done = in_progress && (count_q == `MD_COUNT_WIDTH'(`MD_ITERATIONS));

	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
		begin
			op_q <= MD_MULT;
			count_q <= '0;
			in_progress <= 1'b0;
			result_ready <= 1'b0;
			result <= '0;
			exception <= 1'b0;
		end
		else
		begin
			result_ready <= 1'b0;
			// A strobe mid-run simply restarts
			if (start)
			begin
				op_q <= op;
				count_q <= '0;
				in_progress <= 1'b1;
			end
			else if (done)
			begin
				in_progress <= 1'b0;
				result_ready <= 1'b1;
				result <= (op_q == MD_MULT) ? mult_result : div_result;
				exception <= (op_q == MD_MULT) ? mult_exception : div_exception;
			end
			else if (in_progress)
			begin
				count_q <= count_q + 1'b1;
			end
		end
	end

endmodule

/* hw/multdiv.sv */
`timescale 1ns/1ps
`include "multdiv_config.svh"

module multdiv (
	input  logic                 clock,
	input  logic                 arst_n,
	input  logic                 start_mult,
	input  logic                 start_div,
	input  logic [`MD_WIDTH-1:0] operand_a,
	input  logic [`MD_WIDTH-1:0] operand_b,
	output logic [`MD_WIDTH-1:0] result,
	output logic                 exception,
	output logic                 result_ready,
	output logic                 in_progress
);
	import multdiv_pkg::*;

	md_op_e               op;
	logic                 mult_start;
	logic                 div_start;
	logic [`MD_WIDTH-1:0] mult_result;
	logic [`MD_WIDTH-1:0] div_result;
	logic                 mult_exception;
	logic                 div_exception;
	md_step_t             mult_step;
	md_step_t             div_step;
	md_step_t             dp_step;
	md_state_t            dp_state;

	md_control i_control (
		.clock          (clock),
		.arst_n         (arst_n),
		.start_mult     (start_mult),
		.start_div      (start_div),
		.mult_result    (mult_result),
		.div_result     (div_result),
		.mult_exception (mult_exception),
		.div_exception  (div_exception),
		.mult_start     (mult_start),
		.div_start      (div_start),
		.op             (op),
		.result         (result),
		.exception      (exception),
		.result_ready   (result_ready),
		.in_progress    (in_progress)
	);

	mult_seq i_mult (
		.clock        (clock),
		.arst_n       (arst_n),
		.start        (mult_start),
		.multiplicand (operand_a),
		.multiplier   (operand_b),
		.state        (dp_state),
		.step         (mult_step),
		.product_low  (mult_result),
		.overflow     (mult_exception)
	);

	div_seq i_div (
		.clock          (clock),
		.arst_n         (arst_n),
		.start          (div_start),
		.dividend       (operand_a),
		.divisor        (operand_b),
		.state          (dp_state),
		.step           (div_step),
		.quotient       (div_result),
		.divide_by_zero (div_exception)
	);

	// Only the selected sequencer reaches the shared datapath
	assign dp_step = (op == MD_MULT) ? mult_step : div_step;

	md_datapath i_datapath (
		.clock  (clock),
		.arst_n (arst_n),
		.step   (dp_step),
		.state  (dp_state)
	);

endmodule

/* test/multdiv_assert.sv */
`timescale 1ns/1ps

module multdiv_assert (
	input logic clock,
	input logic arst_n,
	input logic start_mult,
	input logic start_div,
	input logic result_ready,
	input logic in_progress
);

	int         ready_failures = 0;
	int         latency_failures = 0;
	int         reset_failures = 0;
	logic       strobe;
	logic [5:0] since_strobe;

	assign strobe = start_mult | start_div;

	// Edges since the last strobe, saturating
	always_ff @(posedge clock or negedge arst_n)
	begin
		if (!arst_n)
			since_strobe <= '0;
		else if (strobe)
			since_strobe <= 6'd1;
		else if (since_strobe != 6'd0 && since_strobe != 6'd63)
			since_strobe <= since_strobe + 6'd1;
	end

	ready_single: assert property (@(posedge clock) disable iff (!arst_n)
		result_ready |=> !result_ready)
	else
	begin
		$error("result_ready stayed high for more than one cycle");
		ready_failures++;
	end

	ready_on_time: assert property (@(posedge clock) disable iff (!arst_n)
		(since_strobe == 6'd33 && !strobe) |=> result_ready)
	else
	begin
		$error("result_ready missing 33 cycles after a strobe");
		latency_failures++;
	end

	ready_not_early: assert property (@(posedge clock) disable iff (!arst_n)
		result_ready |-> since_strobe == 6'd34)
	else
	begin
		$error("result_ready at the wrong distance from the last strobe");
		latency_failures++;
	end

	idle_after_reset: assert property (@(posedge clock)
		$rose(arst_n) |-> !in_progress && !result_ready)
	else
	begin
		$error("unit busy right after reset");
		reset_failures++;
	end

endmodule

bind multdiv multdiv_assert i_multdiv_assert (
	.clock        (clock),
	.arst_n       (arst_n),
	.start_mult   (start_mult),
	.start_div    (start_div),
	.result_ready (result_ready),
	.in_progress  (in_progress)
);

/* test/multdiv_tb.sv */
`timescale 1ns/1ps
`include "multdiv_config.svh"

module multdiv_tb;

	localparam int LATENCY = 33;
	localparam int CYCLES_PER_TEST = 40;
	localparam int ABORT_GAP = 8;
	localparam int RANDOM_TESTS = 8;

	// Operation codes of the tests file
	typedef struct packed {
		logic [3:0]           op;
		logic [`MD_WIDTH-1:0] a;
		logic [`MD_WIDTH-1:0] b;
		logic [`MD_WIDTH-1:0] result;
		logic                 exception;
	} test_vec_t;

	logic                 clock;
	logic                 arst_n;
	logic                 start_mult;
	logic                 start_div;
	logic [`MD_WIDTH-1:0] operand_a;
	logic [`MD_WIDTH-1:0] operand_b;
	logic [`MD_WIDTH-1:0] result;
	logic                 exception;
	logic                 result_ready;
	logic                 in_progress;

	test_vec_t            tests[$];
	logic [`MD_WIDTH-1:0] prev_result;
	integer               seed;
	int                   error_count = 0;
	int                   check_count = 0;
	int                   cycle_count = 0;
	int                   cycle_limit;
	int                   abort_count;

	multdiv i_dut (
		.clock        (clock),
		.arst_n       (arst_n),
		.start_mult   (start_mult),
		.start_div    (start_div),
		.operand_a    (operand_a),
		.operand_b    (operand_b),
		.result       (result),
		.exception    (exception),
		.result_ready (result_ready),
		.in_progress  (in_progress)
	);

	always #20 clock = ~clock;

	always @(posedge clock)
	begin
		cycle_count++;
		if (cycle_count > cycle_limit)
		begin
			$display("Timeout after %0d cycles, the unit stopped answering", cycle_count);
			$display("Errors found");
			$finish;
		end
	end

	task automatic compare(input string name, input logic [31:0] actual,
		input logic [31:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			$display("ERROR %s: got %h, expected %h", name, actual, expected);
			error_count++;
		end
	endtask

	// Signed product low word, or quotient truncated toward zero
	function automatic logic [32:0] expected_outcome(input logic [3:0] op,
		input logic [31:0] a, input logic [31:0] b);
		logic signed [63:0] wide_a;
		logic signed [63:0] wide_b;
		logic signed [63:0] value;
		logic               exc;
		wide_a = {{32{a[31]}}, a};
		wide_b = {{32{b[31]}}, b};
		if (op == 4'd1 || op == 4'd4)
		begin
			if (b == 32'd0)
				return {1'b1, 32'd0};
			value = wide_a / wide_b;
			exc = 1'b0;
		end
		else
		begin
			value = wide_a * wide_b;
			exc = (value != {{32{value[31]}}, value[31:0]});
		end
		return {exc, value[31:0]};
	endfunction

	task automatic load_tests();
		int          fd;
		int          fields;
		string       line;
		logic [31:0] v_op;
		logic [31:0] v_a;
		logic [31:0] v_b;
		logic [31:0] v_res;
		logic [31:0] v_exc;
		test_vec_t   t;
		fd = $fopen("test/multdiv_tests.txt", "r");
		if (fd == 0)
		begin
			$display("Cannot open test/multdiv_tests.txt");
			error_count++;
		end
		else
		begin
			while ($fgets(line, fd) != 0)
			begin
				if (line.len() == 0 || line[0] == "#" || line[0] == "\n")
					continue;
				fields = $sscanf(line, "%h %h %h %h %h", v_op, v_a, v_b, v_res, v_exc);
				if (fields != 5 || v_op > 32'd4)
				begin
					$display("Unreadable line in the tests file: %s", line);
					error_count++;
				end
				else
				begin
					t.op = v_op[3:0];
					t.a = v_a;
					t.b = v_b;
					t.result = v_res;
					t.exception = v_exc[0];
					tests.push_back(t);
				end
			end
			$fclose(fd);
		end
	endtask

	task automatic add_random_tests();
		logic [31:0] pick;
		test_vec_t   t;
		for (int i = 0; i < RANDOM_TESTS; i++)
		begin
			pick = $random(seed);
			t.op = {3'b000, pick[0]};
			t.a = $random(seed);
			// Smaller second operands give products that fit more often
			t.b = $random(seed) >> pick[5:1];
			{t.exception, t.result} = expected_outcome(t.op, t.a, t.b);
			tests.push_back(t);
		end
	endtask

	task automatic drive_strobe(input logic mult, input logic div,
		input logic [31:0] a, input logic [31:0] b);
		@(posedge clock);
		start_mult <= mult;
		start_div <= div;
		operand_a <= a;
		operand_b <= b;
		@(posedge clock);
		start_mult <= 1'b0;
		start_div <= 1'b0;
		// Operands only count in the strobe cycle
		operand_a <= ~a;
		operand_b <= ~b;
	endtask

	task automatic watch_no_result(input int cycles);
		repeat (cycles)
		begin
			@(negedge clock);
			compare("result_ready", 32'(result_ready), 32'd0);
			compare("in_progress", 32'(in_progress), 32'd1);
			compare("result", result, prev_result);
		end
	endtask

	task automatic wait_for_result();
		int cycles;
		cycles = 0;
		@(negedge clock);
		while (!result_ready)
		begin
			compare("in_progress", 32'(in_progress), 32'd1);
			compare("result", result, prev_result);
			cycles++;
			@(negedge clock);
		end
		compare("latency", cycles, LATENCY);
		compare("in_progress", 32'(in_progress), 32'd0);
	endtask

	task automatic run_test(input test_vec_t t, input int index);
		int errors_before;
		errors_before = error_count;
		case (t.op)
			4'd0: drive_strobe(1'b1, 1'b0, t.a, t.b);
			4'd1: drive_strobe(1'b0, 1'b1, t.a, t.b);
			4'd2: drive_strobe(1'b1, 1'b1, t.a, t.b);
			4'd3:
			begin
				drive_strobe(1'b0, 1'b1, t.a, t.b);
				watch_no_result(ABORT_GAP);
				drive_strobe(1'b1, 1'b0, t.a, t.b);
			end
			default:
			begin
				// Multiply cut short by a divide
				drive_strobe(1'b1, 1'b0, t.a, t.b);
				watch_no_result(ABORT_GAP);
				drive_strobe(1'b0, 1'b1, t.a, t.b);
			end
		endcase
		wait_for_result();
		compare("result", result, t.result);
		compare("exception", 32'(exception), 32'(t.exception));
		prev_result = result;
		repeat (2)
		begin
			@(negedge clock);
			compare("result_ready", 32'(result_ready), 32'd0);
			compare("result", result, prev_result);
		end
		$display("Test %0d op %0d a=%h b=%h result=%h exception=%0b %s", index, t.op,
			t.a, t.b, result, exception, (error_count == errors_before) ? "ok" : "mismatch");
	endtask

	initial
	begin
		clock = 1'b0;
		arst_n = 1'b0;
		start_mult = 1'b0;
		start_div = 1'b0;
		operand_a = '0;
		operand_b = '0;
		prev_result = '0;
		seed = 32'hb3a2;
		load_tests();
		add_random_tests();
		abort_count = 0;
		foreach (tests[i])
			if (tests[i].op > 4'd2)
				abort_count++;
		cycle_limit = tests.size() * CYCLES_PER_TEST + abort_count * ABORT_GAP + 100;
		repeat (3) @(posedge clock);
		arst_n <= 1'b1;
		@(negedge clock);
		compare("result", result, 32'd0);
		compare("exception", 32'(exception), 32'd0);
		compare("result_ready", 32'(result_ready), 32'd0);
		compare("in_progress", 32'(in_progress), 32'd0);
		foreach (tests[i])
			run_test(tests[i], i);
		error_count += i_dut.i_multdiv_assert.ready_failures +
			i_dut.i_multdiv_assert.latency_failures + i_dut.i_multdiv_assert.reset_failures;
		$display("Tests run: %0d, checks: %0d, errors: %0d", tests.size(), check_count,
			error_count);
		if (error_count == 0)
			$display("No errors");
		else
			$display("Errors found");
		$finish;
	end

endmodule

/* test/multdiv_tests.txt */
# op operand_a operand_b result exception, all hex
# op 0 mult, 1 div, 2 both strobes, 3 div cut by mult, 4 mult cut by div
0 00000007 00000006 0000002a 0
0 fffffff9 00000006 ffffffd6 0
0 fffffff9 fffffffa 0000002a 0
0 00001234 00005678 06260060 0
0 fffffc18 000003e8 fff0bdc0 0
0 80000000 00000001 80000000 0
0 00000000 deadbeef 00000000 0
0 7fffffff 00000002 fffffffe 1
0 00010000 00010000 00000000 1
0 80000000 ffffffff 80000000 1
0 ffff0000 00010000 00000000 1
1 00000064 00000007 0000000e 0
1 ffffff9c 00000007 fffffff2 0
1 00000064 fffffff9 fffffff2 0
1 ffffff9c fffffff9 0000000e 0
1 80000000 00000002 c0000000 0
1 7fffffff 7fffffff 00000001 0
1 00000005 00000007 00000000 0
1 fffffffb 00000007 00000000 0
1 00001234 00000000 00000000 1
1 80000000 00000000 00000000 1
2 00000009 fffffffd ffffffe5 0
3 00000064 00000003 0000012c 0
3 00000005 00000000 00000000 0
4 00000064 00000003 00000021 0
4 00000005 00000000 00000000 1

/* vlog.f */
+incdir+hw
hw/multdiv_pkg.sv
hw/md_datapath.sv
hw/mult_seq.sv
hw/div_seq.sv
hw/md_control.sv
hw/multdiv.sv
test/multdiv_assert.sv
test/multdiv_tb.sv

/* Makefile */
OBJ_DIR = obj_dir

.PHONY: compile run clean

compile:
	verilator --binary --assert -j 0 --top-module multdiv_tb -Mdir $(OBJ_DIR) -f vlog.f

run: compile
	./$(OBJ_DIR)/Vmultdiv_tb | tee sim.log
	grep -q "^No errors$$" sim.log

clean:
	rm -rf $(OBJ_DIR) sim.log
